/* Makefile */
# Verilator build for the cartridge core testbench.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_fcart
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

SOURCES := $(wildcard design/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

# the simulator exits with a failing status when the testbench calls $fatal.
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* design/bus_decode.sv */
`timescale 1ns/1ns

module bus_decode #(
    parameter int RAM_ADDR_BITS = 16
) (
    input  logic                     m2,
    input  logic                     arst_n,

    // CPU side
    input  logic [14:0]              cpu_addr,
    input  logic                     cpu_rw,
    input  logic                     rom_ce_n,
    output logic [7:0]               cpu_data_out,
    output logic                     cpu_dir,

    // PPU side
    input  logic [13:0]              ppu_addr,
    input  logic                     ppu_rd_n,
    output logic [7:0]               ppu_data_out,
    output logic                     ppu_dir,
    output logic                     ciram_ce_n,
    output logic                     ciram_a10,

    // configuration from the loader
    input  logic [RAM_ADDR_BITS-1:0] prg_base,
    input  logic [RAM_ADDR_BITS-1:0] chr_base,
    input  fcart_pkg::mirror_e       mirror,
    input  logic                     loading,

    // memory read ports
    output logic [RAM_ADDR_BITS-1:0] prg_addr,
    output logic [RAM_ADDR_BITS-1:0] chr_addr,
    input  logic [7:0]               prg_rdata,
    input  logic [7:0]               chr_rdata
);
    logic [1:0] loading_sync;
    logic       loading_s;
    logic       cpu_read;
    logic       ppu_read;

    // the buses stay released from reset until loading has been seen low twice.
    always_ff @(posedge m2 or negedge arst_n) begin
        if (!arst_n) begin
            loading_sync <= 2'b11;
        end else begin
            loading_sync <= {loading_sync[0], loading};
        end
    end

    assign loading_s = loading_sync[1];

    // ROM reads on the CPU side, pattern table reads on the PPU side.
    assign cpu_read = !loading_s && !rom_ce_n && cpu_rw;
    assign ppu_read = !loading_s && !ppu_addr[13] && !ppu_rd_n;

    // bases are aligned to the window size, so OR acts as an add.
    assign prg_addr = RAM_ADDR_BITS'(cpu_addr) | prg_base;
    assign chr_addr = RAM_ADDR_BITS'(ppu_addr[12:0]) | chr_base;

    assign cpu_dir      = cpu_read;
    assign ppu_dir      = ppu_read;
    assign cpu_data_out = cpu_read ? prg_rdata : 8'h00;
    assign ppu_data_out = ppu_read ? chr_rdata : 8'h00;

    // nametables live in the console's CIRAM from 0x2000 up.
    assign ciram_ce_n = ~ppu_addr[13];
    assign ciram_a10  = (mirror == fcart_pkg::MIRROR_VERT) ? ppu_addr[10] : ppu_addr[11];

endmodule

/* design/cart_mem.sv */
`timescale 1ns/1ns

module cart_mem #(
    parameter int RAM_ADDR_BITS = 16
) (
    input  logic                     m2,

    input  fcart_pkg::mem_wr_t       mem_wr,

    input  logic [RAM_ADDR_BITS-1:0] prg_addr,
    output logic [7:0]               prg_rdata,

    input  logic [RAM_ADDR_BITS-1:0] chr_addr,
    output logic [7:0]               chr_rdata
);
    localparam int DEPTH = 2 ** RAM_ADDR_BITS;

    // backing store for both the PRG and the CHR image.
    logic [7:0] mem [DEPTH];

    logic [RAM_ADDR_BITS-1:0] wr_addr;

    assign wr_addr = mem_wr.addr[RAM_ADDR_BITS-1:0];

    always_ff @(posedge m2) begin
        if (mem_wr.en) begin
            mem[wr_addr] <= mem_wr.data;
        end
    end

    // both read ports are registered.
    // a read on the same edge as a write to the same byte returns the old value.
    always_ff @(posedge m2) begin
        prg_rdata <= mem[prg_addr];
    end

    always_ff @(posedge m2) begin
        chr_rdata <= mem[chr_addr];
    end

endmodule

/* design/cfg_loader.sv */
`timescale 1ns/1ns

module cfg_loader #(
    parameter int RAM_ADDR_BITS  = 16,
    parameter int CMD_FIFO_DEPTH = 4
) (
    input  logic                     m2,
    input  logic                     arst_n,

    input  fcart_pkg::host_cmd_t     host_cmd,
    input  logic                     host_valid,
    output logic                     host_credit,

    output fcart_pkg::mem_wr_t       mem_wr,

    output logic [RAM_ADDR_BITS-1:0] prg_base,
    output logic [RAM_ADDR_BITS-1:0] chr_base,
    output fcart_pkg::mirror_e       mirror,
    output logic                     loading
);
    localparam int PTR_BITS = (CMD_FIFO_DEPTH > 1) ? $clog2(CMD_FIFO_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(CMD_FIFO_DEPTH + 1);

    fcart_pkg::host_cmd_t fifo_mem [CMD_FIFO_DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                push;
    logic                pop;
    fcart_pkg::host_cmd_t head;

    function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(CMD_FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // a full FIFO means the host has no credit left, so the command is dropped.
    assign push = host_valid && (count != CNT_BITS'(CMD_FIFO_DEPTH));

    // the head is consumed in every cycle that the FIFO holds something.
    assign pop  = (count != '0);
    assign head = fifo_mem[rd_ptr];

    always_ff @(posedge m2) begin
        if (push) begin
            fifo_mem[wr_ptr] <= host_cmd;
        end
    end

    always_ff @(posedge m2 or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            host_credit <= 1'b0;
        end else begin
            // one credit goes back for each popped command, a cycle after the pop.
            host_credit <= pop;
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // configuration registers change on the edge that pops the command.
    always_ff @(posedge m2 or negedge arst_n) begin
        if (!arst_n) begin
            prg_base <= '0;
            chr_base <= '0;
            mirror   <= fcart_pkg::MIRROR_VERT;
            loading  <= 1'b1;
        end else if (pop) begin
            case (head.op)
                fcart_pkg::OP_SET_PRG_BASE: begin
                    prg_base <= head.addr[RAM_ADDR_BITS-1:0];
                end
                fcart_pkg::OP_SET_CHR_BASE: begin
                    chr_base <= head.addr[RAM_ADDR_BITS-1:0];
                end
                fcart_pkg::OP_SET_MIRROR: begin
                    mirror <= fcart_pkg::mirror_e'(head.data[0]);
                end
                fcart_pkg::OP_LOAD_BEGIN: begin
                    loading <= 1'b1;
                end
                fcart_pkg::OP_LOAD_END: begin
                    loading <= 1'b0;
                end
                default: begin
                    loading <= loading;
                end
            endcase
        end
    end

    // the write is presented while the command sits at the head,
    // so the memory takes it on the pop edge.
    // writes outside the loading window are discarded but still cost a pop
    always_comb begin
        mem_wr.en   = pop && (head.op == fcart_pkg::OP_WRITE) && loading;
        mem_wr.addr = head.addr;
        mem_wr.data = head.data;
    end

endmodule

/* design/fcart_pkg.sv */
package fcart_pkg;

    // host command opcodes, as carried in host_cmd_t.op.
    typedef enum logic [2:0] {
        OP_NOP          = 3'd0,
        OP_SET_PRG_BASE = 3'd1,
        OP_SET_CHR_BASE = 3'd2,
        OP_SET_MIRROR   = 3'd3,
        OP_WRITE        = 3'd4,
        OP_LOAD_BEGIN   = 3'd5,
        OP_LOAD_END     = 3'd6
    } host_op_e;

    // one host command.
    // addr is a byte address for OP_WRITE and a base value for the base opcodes.
    // data bit 0 carries the mirroring value for OP_SET_MIRROR.
    typedef struct packed {
        host_op_e    op;
        logic [23:0] addr;
        logic [7:0]  data;
    } host_cmd_t;

    // nametable mirroring.
    // vertical takes CIRAM A10 from PPU A10, horizontal from PPU A11.
    typedef enum logic {
        MIRROR_VERT = 1'b0,
        MIRROR_HORZ = 1'b1
    } mirror_e;

    // a single byte write into the cartridge memory.
    // the memory only looks at the low address bits it has.
    typedef struct packed {
        logic        en;
        logic [23:0] addr;
        logic [7:0]  data;
    } mem_wr_t;

endpackage

/* design/fcart_top.sv */
`timescale 1ns/1ns

module fcart_top #(
    parameter int RAM_ADDR_BITS  = 16,
    parameter int CMD_FIFO_DEPTH = 4
) (
    input  logic                 m2,
    input  logic                 arst_n,

    // host command port
    input  fcart_pkg::host_cmd_t host_cmd,
    input  logic                 host_valid,
    output logic                 host_credit,

    // CPU bus
    input  logic [14:0]          cpu_addr,
    input  logic                 cpu_rw,
    input  logic                 rom_ce_n,
    output logic [7:0]           cpu_data_out,
    output logic                 cpu_dir,

    // PPU bus
    input  logic [13:0]          ppu_addr,
    input  logic                 ppu_rd_n,
    output logic [7:0]           ppu_data_out,
    output logic                 ppu_dir,
    output logic                 ciram_ce_n,
    output logic                 ciram_a10
);
    logic [RAM_ADDR_BITS-1:0] prg_base;
    logic [RAM_ADDR_BITS-1:0] chr_base;
    fcart_pkg::mirror_e       mirror;
    logic                     loading;
    fcart_pkg::mem_wr_t       mem_wr;
    logic [RAM_ADDR_BITS-1:0] prg_addr;
    logic [RAM_ADDR_BITS-1:0] chr_addr;
    logic [7:0]               prg_rdata;
    logic [7:0]               chr_rdata;

    cfg_loader #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS),
        .CMD_FIFO_DEPTH(CMD_FIFO_DEPTH)
    ) u_cfg_loader (
        .m2         (m2),
        .arst_n     (arst_n),
        .host_cmd   (host_cmd),
        .host_valid (host_valid),
        .host_credit(host_credit),
        .mem_wr     (mem_wr),
        .prg_base   (prg_base),
        .chr_base   (chr_base),
        .mirror     (mirror),
        .loading    (loading)
    );

    cart_mem #(
        .RAM_ADDR_BITS(RAM_ADDR_BITS)
    ) u_cart_mem (
        .m2       (m2),
        .mem_wr   (mem_wr),
        .prg_addr (prg_addr),
        .prg_rdata(prg_rdata),
        .chr_addr (chr_addr),
        .chr_rdata(chr_rdata)
    );

    bus_decode #(
        .RAM_ADDR_BITS(RAM_ADDR_BITS)
    ) u_bus_decode (
        .m2          (m2),
        .arst_n      (arst_n),
        .cpu_addr    (cpu_addr),
        .cpu_rw      (cpu_rw),
        .rom_ce_n    (rom_ce_n),
        .cpu_data_out(cpu_data_out),
        .cpu_dir     (cpu_dir),
        .ppu_addr    (ppu_addr),
        .ppu_rd_n    (ppu_rd_n),
        .ppu_data_out(ppu_data_out),
        .ppu_dir     (ppu_dir),
        .ciram_ce_n  (ciram_ce_n),
        .ciram_a10   (ciram_a10),
        .prg_base    (prg_base),
        .chr_base    (chr_base),
        .mirror      (mirror),
        .loading     (loading),
        .prg_addr    (prg_addr),
        .chr_addr    (chr_addr),
        .prg_rdata   (prg_rdata),
        .chr_rdata   (chr_rdata)
    );

endmodule

/* flist.f */
+incdir+tests
design/fcart_pkg.sv
design/cfg_loader.sv
design/cart_mem.sv
design/bus_decode.sv
design/fcart_top.sv
tests/tb_fcart.sv

/* tests/tb_fcart_vectors.svh */
`ifndef TB_FCART_VECTORS_SVH
`define TB_FCART_VECTORS_SVH

// columns are is_ppu, bus address, rom_ce_n or ppu_rd_n, cpu_rw,
// expected dir, expected ciram_ce_n and expected ciram_a10.
// expected data comes from the reference memory whenever dir is expected high.
// the CIRAM columns of CPU rows are not checked.

localparam int NUM_VECS        = 32;
localparam int SEG_RESET_FIRST = 0;
localparam int SEG_A_FIRST     = 4;
localparam int SEG_B_FIRST     = 18;
localparam int SEG_C_FIRST     = 28;

localparam vec_t VECTORS [NUM_VECS] = '{
    // still loading after reset, vertical mirroring.
    '{1'b0, 16'h0005, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{1'b0, 16'h7FFC, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{1'b1, 16'h0010, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0},
    '{1'b1, 16'h2400, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1},
    // loaded, both bases at zero, vertical mirroring.
    '{1'b0, 16'h0000, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0},
    '{1'b0, 16'h001F, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0},
    '{1'b0, 16'h4010, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0},
    '{1'b0, 16'h7FFC, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0},
    '{1'b0, 16'h7FFD, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0},
    '{1'b0, 16'h0005, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0},
    '{1'b0, 16'h0005, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{1'b1, 16'h0003, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0},
    '{1'b1, 16'h1FF0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1},
    '{1'b1, 16'h0003, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0},
    '{1'b1, 16'h2000, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{1'b1, 16'h2400, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1},
    '{1'b1, 16'h2800, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{1'b1, 16'h3C00, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1},
    // PRG base 0x8000, CHR base 0xA000, horizontal mirroring.
    '{1'b0, 16'h0003, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0},
    '{1'b0, 16'h0010, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0},
    '{1'b0, 16'h7FFA, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0},
    '{1'b0, 16'h7FFF, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0},
    '{1'b0, 16'h7FFF, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{1'b1, 16'h0001, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0},
    '{1'b1, 16'h1FE8, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1},
    '{1'b1, 16'h2400, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{1'b1, 16'h2800, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1},
    '{1'b1, 16'h2C00, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1},
    // loading reopened, so both buses stay released.
    '{1'b0, 16'h0003, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{1'b0, 16'h7FFF, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0},
    '{1'b1, 16'h0001, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0},
    '{1'b1, 16'h2800, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1}
};

`endif

/* tests/tb_fcart.sv */
`timescale 1ns/1ns

module tb_fcart;

    localparam int RAM_BITS    = 16;
    localparam int FIFO_DEPTH  = 4;
    localparam int CLK_PERIOD  = 40;
    localparam int IMG_BYTES   = 256;
    localparam int CREDIT_WAIT = 32;

    // one row of the read table.
    // sel_n is rom_ce_n for a CPU row and ppu_rd_n for a PPU row.
    typedef struct packed {
        logic        is_ppu;
        logic [15:0] addr;
        logic        sel_n;
        logic        rw;
        logic        exp_dir;
        logic        exp_ce_n;
        logic        exp_a10;
    } vec_t;

    `include "tb_fcart_vectors.svh"

    localparam int WATCHDOG_CYCLES = NUM_VECS + IMG_BYTES + 200;

    logic                 m2;
    logic                 arst_n;
    fcart_pkg::host_cmd_t host_cmd;
    logic                 host_valid;
    logic                 host_credit;
    logic [14:0]          cpu_addr;
    logic                 cpu_rw;
    logic                 rom_ce_n;
    logic [7:0]           cpu_data_out;
    logic                 cpu_dir;
    logic [13:0]          ppu_addr;
    logic                 ppu_rd_n;
    logic [7:0]           ppu_data_out;
    logic                 ppu_dir;
    logic                 ciram_ce_n;
    logic                 ciram_a10;

    // reference copy of every byte written inside the loading window.
    logic [7:0]  ref_mem [2**RAM_BITS];
    logic [15:0] prg_base_model;
    logic [15:0] chr_base_model;
    logic [15:0] img_addr;
    logic [7:0]  img_byte;
    int          seed;
    int          sent = 0;
    int          returned = 0;

    fcart_top #(
        .RAM_ADDR_BITS (RAM_BITS),
        .CMD_FIFO_DEPTH(FIFO_DEPTH)
    ) DUT (
        .m2          (m2),
        .arst_n      (arst_n),
        .host_cmd    (host_cmd),
        .host_valid  (host_valid),
        .host_credit (host_credit),
        .cpu_addr    (cpu_addr),
        .cpu_rw      (cpu_rw),
        .rom_ce_n    (rom_ce_n),
        .cpu_data_out(cpu_data_out),
        .cpu_dir     (cpu_dir),
        .ppu_addr    (ppu_addr),
        .ppu_rd_n    (ppu_rd_n),
        .ppu_data_out(ppu_data_out),
        .ppu_dir     (ppu_dir),
        .ciram_ce_n  (ciram_ce_n),
        .ciram_a10   (ciram_a10)
    );

    initial begin
        m2 = 1'b0;
        forever #(CLK_PERIOD / 2) m2 = ~m2;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired at %0t before the test sequence finished", $time);
        $display("Simulation failed");
        $fatal(1, "watchdog timeout");
    end

    // host_credit is a registered pulse, so the value seen at a rising edge
    // belongs to the cycle that just ended.
    always @(posedge m2) begin
        if (arst_n && host_credit) begin
            if (returned >= sent) begin
                $display("credit returned at %0t with no command outstanding", $time);
                $display("Simulation failed");
                $fatal(1, "unexpected credit");
            end else begin
                returned <= returned + 1;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic send_cmd(input fcart_pkg::host_op_e op, input logic [23:0] addr,
                            input logic [7:0] data);
        while (sent - returned >= FIFO_DEPTH) begin
            @(negedge m2);
        end
        host_cmd.op   = op;
        host_cmd.addr = addr;
        host_cmd.data = data;
        host_valid    = 1'b1;
        sent          = sent + 1;
        @(negedge m2);
        host_valid    = 1'b0;
        host_cmd.op   = fcart_pkg::OP_NOP;
    endtask

    task automatic wait_credits(input int extra_cycles);
        int waited;
        waited = 0;
        while (returned != sent && waited < CREDIT_WAIT) begin
            @(negedge m2);
            waited++;
        end
        if (returned != sent) begin
            $display("only %0d of %0d credits came back by %0t", returned, sent, $time);
            $display("Simulation failed");
            $fatal(1, "credit wait timed out");
        end else begin
            repeat (extra_cycles) @(negedge m2);
        end
    endtask

    // image bytes go into eight 32-byte regions that the read table visits.
    function automatic logic [15:0] image_addr(input int idx);
        logic [15:0] region;
        case (idx / 32)
            0:       region = 16'h0000;
            1:       region = 16'h1FE0;
            2:       region = 16'h4000;
            3:       region = 16'h7FE0;
            4:       region = 16'h8000;
            5:       region = 16'hA000;
            6:       region = 16'hBFE0;
            default: region = 16'hFFE0;
        endcase
        return region | 16'(idx % 32);
    endfunction

    task automatic apply_vector(input vec_t v);
        if (v.is_ppu) begin
            cpu_addr = 15'h0000;
            cpu_rw   = 1'b1;
            rom_ce_n = 1'b1;
            ppu_addr = v.addr[13:0];
            ppu_rd_n = v.sel_n;
        end else begin
            cpu_addr = v.addr[14:0];
            cpu_rw   = v.rw;
            rom_ce_n = v.sel_n;
            ppu_addr = 14'h0000;
            ppu_rd_n = 1'b1;
        end
    endtask

    task automatic check_vector(input vec_t v);
        logic [15:0] mem_addr;
        logic [7:0]  exp_data;
        if (v.is_ppu) begin
            mem_addr = {3'b000, v.addr[12:0]} | chr_base_model;
            exp_data = v.exp_dir ? ref_mem[mem_addr] : 8'h00;
            check_value("ppu_dir", 32'(ppu_dir), 32'(v.exp_dir));
            check_value("ppu_data_out", 32'(ppu_data_out), 32'(exp_data));
            check_value("ciram_ce_n", 32'(ciram_ce_n), 32'(v.exp_ce_n));
            check_value("ciram_a10", 32'(ciram_a10), 32'(v.exp_a10));
            check_value("cpu_dir", 32'(cpu_dir), 32'd0);
        end else begin
            mem_addr = {1'b0, v.addr[14:0]} | prg_base_model;
            exp_data = v.exp_dir ? ref_mem[mem_addr] : 8'h00;
            check_value("cpu_dir", 32'(cpu_dir), 32'(v.exp_dir));
            check_value("cpu_data_out", 32'(cpu_data_out), 32'(exp_data));
            check_value("ppu_dir", 32'(ppu_dir), 32'd0);
        end
    endtask

    task automatic run_vectors(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            apply_vector(VECTORS[i]);
            @(negedge m2);
            check_vector(VECTORS[i]);
        end
    endtask

    initial begin
        seed           = 32'h4eeccf17;
        arst_n         = 1'b0;
        host_cmd.op    = fcart_pkg::OP_NOP;
        host_cmd.addr  = 24'h000000;
        host_cmd.data  = 8'h00;
        host_valid     = 1'b0;
        cpu_addr       = 15'h0000;
        cpu_rw         = 1'b1;
        rom_ce_n       = 1'b1;
        ppu_addr       = 14'h0000;
        ppu_rd_n       = 1'b1;
        prg_base_model = 16'h0000;
        chr_base_model = 16'h0000;
        repeat (4) @(negedge m2);
        arst_n = 1'b1;
        check_value("host_credit", 32'(host_credit), 32'd0);
        run_vectors(SEG_RESET_FIRST, SEG_A_FIRST - 1);

        // the whole credit pool goes out back to back, and every credit must come back.
        repeat (FIFO_DEPTH) send_cmd(fcart_pkg::OP_NOP, 24'h000000, 8'h00);
        wait_credits(0);

        send_cmd(fcart_pkg::OP_LOAD_BEGIN, 24'h000000, 8'h00);
        for (int i = 0; i < IMG_BYTES; i++) begin
            img_addr = image_addr(i);
            img_byte = 8'($random(seed));
            ref_mem[img_addr] = img_byte;
            send_cmd(fcart_pkg::OP_WRITE, {8'h00, img_addr}, img_byte);
        end
        send_cmd(fcart_pkg::OP_LOAD_END, 24'h000000, 8'h00);
        wait_credits(3);
        run_vectors(SEG_A_FIRST, SEG_B_FIRST - 1);

        send_cmd(fcart_pkg::OP_SET_PRG_BASE, 24'h008000, 8'h00);
        send_cmd(fcart_pkg::OP_SET_CHR_BASE, 24'h00A000, 8'h00);
        send_cmd(fcart_pkg::OP_SET_MIRROR, 24'h000000, {7'd0, fcart_pkg::MIRROR_HORZ});
        prg_base_model = 16'h8000;
        chr_base_model = 16'hA000;
        // loading is closed here, so this byte must not reach the memory.
        send_cmd(fcart_pkg::OP_WRITE, 24'h008003, ~ref_mem[16'h8003]);
        wait_credits(1);
        run_vectors(SEG_B_FIRST, SEG_C_FIRST - 1);

        send_cmd(fcart_pkg::OP_LOAD_BEGIN, 24'h000000, 8'h00);
        wait_credits(3);
        run_vectors(SEG_C_FIRST, NUM_VECS - 1);

        $display("Simulation passed");
        $finish;
    end

endmodule
